/* vga_pkg.sv */
// Shared VGA types; the palette is fixed at 256 entries of 12-bit RGB, and geometry is not here
`default_nettype none

package vga_pkg;

  // Palette geometry
  localparam int PAL_DEPTH = 256;
  localparam int IDX_W     = $clog2(PAL_DEPTH);

  // Colour index, FIFO payload and palette address
  typedef logic [IDX_W-1:0] pix_index_t;

  // 4 bits per channel, red in the top nibble
  typedef struct packed
  {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // Shared by both timing axes
  // IDLE only while the display is disabled
  typedef enum logic [2:0]
  {
    IDLE,
    FP,
    SYNC,
    BP,
    ACTIVE
  } vga_state_t;

  // Blank colour
  localparam rgb_t RGB_BLACK = '0;

endpackage

`default_nettype wire

/* line_fifo_intf.sv */
// FIFO push and pop bundle; pop_data is only meaningful while empty is low
`timescale 1ns/1ps
`default_nettype none

interface line_fifo_intf #(
  parameter type payload_t = vga_pkg::pix_index_t
);

  // Push side, host
  logic     push;
  payload_t push_data;
  logic     full;

  // Pop side, first word falls through
  logic     pop;
  payload_t pop_data;
  logic     empty;

  // Host side
  modport writer (output push, output push_data, input full);

  // Storage
  modport fifo (input push, input push_data, output full,
                input pop, output pop_data, output empty);

  // Palette stage
  modport reader (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

/* vga_timing_intf.sv */
// Raster timing bundle; syncs are active high here and inverted only at the pins
`timescale 1ns/1ps
`default_nettype none

interface vga_timing_intf;

  // Pixel strobe, every second clock
  logic tick;

  // Both axes in ACTIVE
  logic active;

  // High during the SYNC region of each axis
  logic hsync;
  logic vsync;

  // Timing generator
  modport source (output tick, output active, output hsync, output vsync);

  // Palette and output stages
  modport sink (input tick, input active, input hsync, input vsync);

endinterface

`default_nettype wire

/* line_fifo.sv */
// FWFT FIFO; pushes while full and pops while empty are ignored, any DEPTH of 2 or more
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter type payload_t = vga_pkg::pix_index_t,
  parameter int  DEPTH     = 16
) (
  input logic         cr_intf,
  input logic         reset,
  line_fifo_intf.fifo fifo
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
  localparam logic [CW-1:0] CNT_FULL = CW'(DEPTH);

  // Storage, no reset
  payload_t mem [DEPTH];

  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  logic [CW-1:0] count;

  logic do_push;
  logic do_pop;

  // Qualified strobes
  assign do_push = fifo.push && !fifo.full;
  assign do_pop  = fifo.pop && !fifo.empty;

  // Flags straight from occupancy
  assign fifo.empty = (count == '0);
  assign fifo.full  = (count == CNT_FULL);

  // Head entry always visible
  assign fifo.pop_data = mem[rd_ptr];

  always_ff @(posedge cr_intf)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= fifo.push_data;
    end
  end

  // Pointers wrap at DEPTH-1, not a power of two in general
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (do_push && !do_pop)
      begin
        count <= count + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Occupancy bound
  a_count_max: assert property (@(posedge cr_intf) disable iff (reset)
    count <= CNT_FULL);

  // Head holds until popped, a push never overwrites it
  a_head_stable: assert property (@(posedge cr_intf) disable iff (reset)
    (!fifo.empty && !fifo.pop) |=> $stable(fifo.pop_data));

endmodule

`default_nettype wire

/* vga_timing.sv */
// Raster timing at half the clock rate; the first line after enable may be one clock short
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input logic            cr_intf,
  input logic            reset,
  input logic            enable,
  vga_timing_intf.source tim
);

  localparam int H_TOTAL = H_FP + H_SYNC + H_BP + H_ACTIVE;
  localparam int V_TOTAL = V_FP + V_SYNC + V_BP + V_ACTIVE;
  localparam int HW      = $clog2(H_TOTAL);
  localparam int VW      = $clog2(V_TOTAL);

  // Last count of each region
  localparam logic [HW-1:0] H_FP_END   = HW'(H_FP - 1);
  localparam logic [HW-1:0] H_SYNC_BEG = HW'(H_FP);
  localparam logic [HW-1:0] H_SYNC_END = HW'(H_FP + H_SYNC - 1);
  localparam logic [HW-1:0] H_BP_END   = HW'(H_FP + H_SYNC + H_BP - 1);
  localparam logic [HW-1:0] H_LAST     = HW'(H_TOTAL - 1);
  localparam logic [VW-1:0] V_FP_END   = VW'(V_FP - 1);
  localparam logic [VW-1:0] V_SYNC_END = VW'(V_FP + V_SYNC - 1);
  localparam logic [VW-1:0] V_BP_END   = VW'(V_FP + V_SYNC + V_BP - 1);
  localparam logic [VW-1:0] V_LAST     = VW'(V_TOTAL - 1);

  logic                 tick_f;
  logic [HW-1:0]        h_cnt;
  logic [VW-1:0]        v_cnt;
  vga_pkg::vga_state_t  h_state;
  vga_pkg::vga_state_t  v_state;

  logic h_adv;
  logic h_wrap;
  logic v_wrap;

  // Region sequencing shared by both axes
  function automatic vga_pkg::vga_state_t step_state(input vga_pkg::vga_state_t cur,
                                                     input logic fp_end,
                                                     input logic sync_end,
                                                     input logic bp_end,
                                                     input logic wrap);
    vga_pkg::vga_state_t nxt;
    nxt = cur;
    case (cur)
      vga_pkg::IDLE:   nxt = vga_pkg::FP;
      vga_pkg::FP:     nxt = fp_end   ? vga_pkg::SYNC   : cur;
      vga_pkg::SYNC:   nxt = sync_end ? vga_pkg::BP     : cur;
      vga_pkg::BP:     nxt = bp_end   ? vga_pkg::ACTIVE : cur;
      vga_pkg::ACTIVE: nxt = wrap     ? vga_pkg::FP     : cur;
      default:         nxt = vga_pkg::IDLE;
    endcase
    return nxt;
  endfunction

  // Horizontal steps per pixel and vertical per line
  assign h_adv  = tick_f && (h_state != vga_pkg::IDLE);
  assign h_wrap = h_adv && (h_cnt == H_LAST);
  assign v_wrap = h_wrap && (v_cnt == V_LAST);

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      tick_f  <= 1'b0;
      h_cnt   <= '0;
      v_cnt   <= '0;
      h_state <= vga_pkg::IDLE;
      v_state <= vga_pkg::IDLE;
    end
    else
    begin
      // Free-running pixel strobe
      tick_f <= ~tick_f;
      if (!enable)
      begin
        h_state <= vga_pkg::IDLE;
        v_state <= vga_pkg::IDLE;
      end
      else
      begin
        h_state <= step_state(h_state, h_adv && (h_cnt == H_FP_END),
                              h_adv && (h_cnt == H_SYNC_END),
                              h_adv && (h_cnt == H_BP_END), h_wrap);
        v_state <= step_state(v_state, h_wrap && (v_cnt == V_FP_END),
                              h_wrap && (v_cnt == V_SYNC_END),
                              h_wrap && (v_cnt == V_BP_END), v_wrap);
      end
      // Counters held at zero in IDLE so FP starts clean
      if (h_state == vga_pkg::IDLE || h_wrap)
        h_cnt <= '0;
      else if (h_adv)
        h_cnt <= h_cnt + 1'b1;
      if (v_state == vga_pkg::IDLE || v_wrap)
        v_cnt <= '0;
      else if (h_wrap)
        v_cnt <= v_cnt + 1'b1;
    end
  end

  assign tim.tick   = tick_f;
  assign tim.active = (h_state == vga_pkg::ACTIVE) && (v_state == vga_pkg::ACTIVE);
  assign tim.hsync  = (h_state == vga_pkg::SYNC);
  assign tim.vsync  = (v_state == vga_pkg::SYNC);

  // hsync only inside the sync window of the counter
  a_hsync_window: assert property (@(posedge cr_intf) disable iff (reset)
    tim.hsync |-> (h_cnt >= H_SYNC_BEG) && (h_cnt <= H_SYNC_END));

  // Active video only past the back porch count of both axes
  a_active_window: assert property (@(posedge cr_intf) disable iff (reset)
    tim.active |-> (h_cnt > H_BP_END) && (v_cnt > V_BP_END));

endmodule

`default_nettype wire

/* palette_lookup.sv */
// Index pop and palette read; host must not rewrite an entry while it is being looked up
`timescale 1ns/1ps
`default_nettype none

module palette_lookup #(
  parameter int RAM_DELAY = 2
) (
  input  logic                cr_intf,
  input  logic                reset,
  line_fifo_intf.reader       fifo,
  vga_timing_intf.sink        tim,
  input  logic                pal_we,
  input  vga_pkg::pix_index_t pal_waddr,
  input  vga_pkg::rgb_t       pal_wdata,
  output vga_pkg::rgb_t       color,
  output logic                color_valid
);

  // Inferred palette RAM written by the host
  vga_pkg::rgb_t pal_ram [vga_pkg::PAL_DEPTH];

  vga_pkg::pix_index_t idx_f;
  logic                idx_vld_f;
  vga_pkg::rgb_t       col_pipe [RAM_DELAY];
  logic [RAM_DELAY-1:0] valid_sr;

  // One index per active pixel and none on underrun
  assign fifo.pop = tim.tick && tim.active && !fifo.empty;

  always_ff @(posedge cr_intf)
  begin
    if (pal_we)
    begin
      pal_ram[pal_waddr] <= pal_wdata;
    end
  end

  // Address register and colour read pipeline
  always_ff @(posedge cr_intf)
  begin
    if (fifo.pop)
    begin
      idx_f <= fifo.pop_data;
    end
    col_pipe[0] <= pal_ram[idx_f];
    for (int i = 1; i < RAM_DELAY; i++)
    begin
      col_pipe[i] <= col_pipe[i-1];
    end
  end

  // Valid tracks the pop through the same depth
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      idx_vld_f <= 1'b0;
      valid_sr  <= '0;
    end
    else
    begin
      idx_vld_f   <= fifo.pop;
      valid_sr[0] <= idx_vld_f;
      for (int i = 1; i < RAM_DELAY; i++)
      begin
        valid_sr[i] <= valid_sr[i-1];
      end
    end
  end

  assign color       = col_pipe[RAM_DELAY-1];
  assign color_valid = valid_sr[RAM_DELAY-1];

  // Every pop yields a colour RAM_DELAY+1 clocks later
  a_pop_latency: assert property (@(posedge cr_intf) disable iff (reset)
    fifo.pop |-> ##(RAM_DELAY + 1) color_valid);

endmodule

`default_nettype wire

/* video_out.sv */
// VGA output registers; syncs and blanking track a palette latency of RAM_DELAY+1 clocks
`timescale 1ns/1ps
`default_nettype none

module video_out #(
  parameter int RAM_DELAY = 2
) (
  input  logic          cr_intf,
  input  logic          reset,
  vga_timing_intf.sink  tim,
  input  vga_pkg::rgb_t color,
  input  logic          color_valid,
  output vga_pkg::rgb_t rgb,
  output logic          hsync_n,
  output logic          vsync_n
);

  localparam int SYNC_DLY = RAM_DELAY + 1;

  logic [SYNC_DLY-1:0] hs_dly;
  logic [SYNC_DLY-1:0] vs_dly;
  // Two pixel-rate stages of blank
  logic [1:0]          blank_f;

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      hs_dly  <= '0;
      vs_dly  <= '0;
      blank_f <= 2'b11;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
      rgb     <= vga_pkg::RGB_BLACK;
    end
    else
    begin
      // Sync delay lines, inverted at the pins
      hs_dly  <= {hs_dly[SYNC_DLY-2:0], tim.hsync};
      vs_dly  <= {vs_dly[SYNC_DLY-2:0], tim.vsync};
      hsync_n <= ~hs_dly[SYNC_DLY-1];
      vsync_n <= ~vs_dly[SYNC_DLY-1];
      if (tim.tick)
      begin
        blank_f <= {blank_f[0], ~tim.active};
      end
      // Blank wins, otherwise new colour, otherwise hold on underrun
      if (blank_f[1])
        rgb <= vga_pkg::RGB_BLACK;
      else if (color_valid)
        rgb <= color;
    end
  end

endmodule

`default_nettype wire

/* vga_display_top.sv */
// Display pipeline top; host and pixel logic share one clock, host must watch full
`timescale 1ns/1ps
`default_nettype none

module vga_display_top #(
  parameter int H_ACTIVE   = 640,
  parameter int H_FP       = 16,
  parameter int H_SYNC     = 96,
  parameter int H_BP       = 48,
  parameter int V_ACTIVE   = 480,
  parameter int V_FP       = 10,
  parameter int V_SYNC     = 2,
  parameter int V_BP       = 33,
  parameter int RAM_DELAY  = 2,
  parameter int FIFO_DEPTH = 16
) (
  input  logic        cr_intf,
  input  logic        reset,
  input  logic        enable,
  input  logic        push,
  input  logic [7:0]  push_data,
  output logic        full,
  input  logic        pal_we,
  input  logic [7:0]  pal_waddr,
  input  logic [11:0] pal_wdata,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue,
  output logic        hsync_n,
  output logic        vsync_n
);

  line_fifo_intf #(.payload_t(vga_pkg::pix_index_t)) fifo_if ();
  vga_timing_intf tim_if ();

  vga_pkg::rgb_t color;
  logic          color_valid;
  vga_pkg::rgb_t out_rgb;

  // Host push side
  assign fifo_if.push      = push;
  assign fifo_if.push_data = push_data;
  assign full              = fifo_if.full;

  line_fifo #(.payload_t(vga_pkg::pix_index_t), .DEPTH(FIFO_DEPTH)) i_line_fifo (
    .cr_intf(cr_intf), .reset(reset), .fifo(fifo_if.fifo));

  vga_timing #(.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
               .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)) i_vga_timing (
    .cr_intf(cr_intf), .reset(reset), .enable(enable), .tim(tim_if.source));

  palette_lookup #(.RAM_DELAY(RAM_DELAY)) i_palette_lookup (
    .cr_intf(cr_intf), .reset(reset), .fifo(fifo_if.reader), .tim(tim_if.sink),
    .pal_we(pal_we), .pal_waddr(pal_waddr), .pal_wdata(pal_wdata),
    .color(color), .color_valid(color_valid));

  video_out #(.RAM_DELAY(RAM_DELAY)) i_video_out (
    .cr_intf(cr_intf), .reset(reset), .tim(tim_if.sink), .color(color),
    .color_valid(color_valid), .rgb(out_rgb), .hsync_n(hsync_n), .vsync_n(vsync_n));

  // Channel split at the pins
  assign red   = out_rgb.r;
  assign green = out_rgb.g;
  assign blue  = out_rgb.b;

endmodule

`default_nettype wire

/* tb_vga_display.sv */
// Small-raster testbench; the feeder keeps the FIFO from running dry, so every active pixel is checked
`timescale 1ns/1ps
`default_nettype none

module tb_vga_display;

  // Small raster so a frame is only a few hundred clocks
  localparam int H_ACTIVE     = 8;
  localparam int H_FP         = 2;
  localparam int H_SYNC       = 3;
  localparam int H_BP         = 2;
  localparam int V_ACTIVE     = 4;
  localparam int V_FP         = 1;
  localparam int V_SYNC       = 2;
  localparam int V_BP         = 1;
  localparam int RAM_DELAY    = 2;
  localparam int FIFO_DEPTH   = 16;
  localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAME_CLK    = 2 * H_TOTAL * V_TOTAL;
  localparam int CLK_PERIOD   = 40;
  localparam int NUM_FRAMES   = 3;
  localparam int REWRITES     = 8;
  // Four frames, the palette load, and some slack
  localparam int WATCHDOG_CLK = 4 * FRAME_CLK + vga_pkg::PAL_DEPTH + 200;

  logic        cr_intf = 1'b0;
  logic        reset;
  logic        enable;
  logic        push;
  logic [7:0]  push_data;
  logic        full;
  logic        pal_we;
  logic [7:0]  pal_waddr;
  logic [11:0] pal_wdata;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic        hsync_n;
  logic        vsync_n;

  // Mirror of the DUT palette
  logic [11:0] pal_model [vga_pkg::PAL_DEPTH];
  // Indices the FIFO accepted in push order
  logic [7:0]  pushed_q [$];

  int   err_cnt   = 0;
  int   px_cnt    = 0;
  int   vs_falls  = 0;
  logic timing_on = 1'b1;

  vga_display_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .RAM_DELAY(RAM_DELAY), .FIFO_DEPTH(FIFO_DEPTH)
  ) i_vga_display_top (
    .cr_intf(cr_intf), .reset(reset), .enable(enable),
    .push(push), .push_data(push_data), .full(full),
    .pal_we(pal_we), .pal_waddr(pal_waddr), .pal_wdata(pal_wdata),
    .red(red), .green(green), .blue(blue), .hsync_n(hsync_n), .vsync_n(vsync_n));

  always #(CLK_PERIOD / 2) cr_intf = ~cr_intf;

  // Expected pixel colour for an index
  function automatic logic [11:0] ref_colour(input logic [7:0] idx);
    return pal_model[idx];
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  // One palette write with the model updated alongside
  task automatic write_palette(input logic [7:0] addr, input logic [11:0] data);
    @(posedge cr_intf);
    pal_we    <= 1'b1;
    pal_waddr <= addr;
    pal_wdata <= data;
    pal_model[addr] = data;
  endtask

  // Half the writes hit the next indices to be shown
  task automatic rewrite_palette(input int count);
    logic [7:0] addr;
    for (int i = 0; i < count; i++)
    begin
      if (i < count / 2 && i < pushed_q.size())
        addr = pushed_q[i];
      else
        addr = 8'($urandom_range(255, 0));
      write_palette(addr, 12'($urandom_range(4095, 1)));
    end
    @(posedge cr_intf);
    pal_we <= 1'b0;
  endtask

  // Feeder keeps push high and logs accepted data
  initial
  begin
    push      = 1'b0;
    push_data = '0;
    forever
    begin
      @(posedge cr_intf);
      if (reset)
        push <= 1'b0;
      else
      begin
        // Without pops the FIFO holds exactly the queued indices
        if (!enable && full !== (pushed_q.size() >= FIFO_DEPTH))
          report_error($sformatf("full=%b with %0d indices queued", full, pushed_q.size()));
        if (push && !full)
        begin
          pushed_q.push_back(push_data);
          push_data <= 8'($urandom_range(255, 0));
        end
        push <= 1'b1;
      end
    end
  end

  // Main sequence
  initial
  begin
    void'($urandom(32'h9a54));
    reset     = 1'b1;
    enable    = 1'b0;
    pal_we    = 1'b0;
    pal_waddr = '0;
    pal_wdata = '0;
    repeat (2) @(posedge cr_intf);
    reset <= 1'b0;
    // Whole palette loaded with no black entry
    for (int a = 0; a < vga_pkg::PAL_DEPTH; a++)
      write_palette(8'(a), 12'($urandom_range(4095, 1)));
    @(posedge cr_intf);
    pal_we <= 1'b0;
    enable <= 1'b1;
    // Rewrite inside each vsync so the next frame uses new colours
    for (int f = 1; f <= NUM_FRAMES; f++)
    begin
      wait (vs_falls == f);
      rewrite_palette(REWRITES);
    end
    wait (vs_falls == NUM_FRAMES + 1);
    @(posedge cr_intf);
    timing_on = 1'b0;
    enable <= 1'b0;
    repeat (20) @(posedge cr_intf);
    if (px_cnt != NUM_FRAMES * V_ACTIVE * H_ACTIVE)
      report_error($sformatf("%0d pixels checked, expected %0d", px_cnt,
                             NUM_FRAMES * V_ACTIVE * H_ACTIVE));
    $display("Summary: %0d errors, %0d pixels checked, %0d vsync pulses",
             err_cnt, px_cnt, vs_falls);
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Monitor samples on the falling edge where outputs are settled
  initial
  begin : monitor
    logic [11:0] rgb_now;
    logic [11:0] rgb_exp;
    logic [7:0]  idx;
    logic        hs_prev;
    logic        vs_prev;
    logic        hs_seen;
    logic        vs_seen;
    int          hs_low;
    int          hs_since;
    int          vs_low;
    int          vs_since;
    int          run_clk;
    int          lines;
    int          quiet;
    hs_prev  = 1'b1;
    vs_prev  = 1'b1;
    hs_seen  = 1'b0;
    vs_seen  = 1'b0;
    hs_low   = 0;
    hs_since = 0;
    vs_low   = 0;
    vs_since = 0;
    run_clk  = 0;
    lines    = 0;
    quiet    = 0;
    forever
    begin
      @(negedge cr_intf);
      rgb_now = {red, green, blue};
      hs_since++;
      vs_since++;
      // Idle outputs once the pipeline has flushed
      quiet = (reset || !enable) ? quiet + 1 : 0;
      if ((reset || quiet > 8) &&
          (hsync_n !== 1'b1 || vsync_n !== 1'b1 || rgb_now !== 12'h000))
        report_error($sformatf("not idle: hsync_n=%b vsync_n=%b rgb=%03h",
                               hsync_n, vsync_n, rgb_now));
      // Black during either sync
      if ((!hsync_n || !vsync_n) && rgb_now != 12'h000)
        report_error($sformatf("rgb=%03h during sync", rgb_now));
      // Horizontal pulse width and period
      if (!hsync_n)
        hs_low++;
      if (hs_prev && !hsync_n)
      begin
        if (timing_on && hs_seen && hs_since != 2 * H_TOTAL)
          report_error($sformatf("hsync period %0d, expected %0d", hs_since, 2 * H_TOTAL));
        hs_seen  = 1'b1;
        hs_since = 0;
        hs_low   = 1;
      end
      else if (!hs_prev && hsync_n && timing_on && hs_seen && hs_low != 2 * H_SYNC)
        report_error($sformatf("hsync width %0d, expected %0d", hs_low, 2 * H_SYNC));
      hs_prev = hsync_n;
      // Vertical pulse width, period and lines per frame
      if (!vsync_n)
        vs_low++;
      if (vs_prev && !vsync_n)
      begin
        if (timing_on && vs_seen && vs_since != FRAME_CLK)
          report_error($sformatf("vsync period %0d, expected %0d", vs_since, FRAME_CLK));
        if (timing_on && vs_falls > 0 && lines != V_ACTIVE)
          report_error($sformatf("%0d lines in frame, expected %0d", lines, V_ACTIVE));
        vs_seen  = 1'b1;
        vs_since = 0;
        vs_low   = 1;
        lines    = 0;
        vs_falls++;
      end
      else if (!vs_prev && vsync_n && timing_on && vs_seen && vs_low != 2 * H_TOTAL * V_SYNC)
        report_error($sformatf("vsync width %0d, expected %0d", vs_low, 2 * H_TOTAL * V_SYNC));
      vs_prev = vsync_n;
      // Pixel compare once per two-clock pixel
      if (rgb_now != 12'h000)
      begin
        if (run_clk % 2 == 0)
        begin
          if (pushed_q.size() == 0)
            report_error("pixel shown with no pushed index left");
          else
          begin
            idx     = pushed_q.pop_front();
            rgb_exp = ref_colour(idx);
            if (rgb_now != rgb_exp)
              report_error($sformatf("pixel %0d index %02h rgb=%03h, expected %03h",
                                     px_cnt, idx, rgb_now, rgb_exp));
            px_cnt++;
          end
        end
        run_clk++;
      end
      else if (run_clk != 0)
      begin
        if (run_clk != 2 * H_ACTIVE)
          report_error($sformatf("line of %0d clocks, expected %0d", run_clk, 2 * H_ACTIVE));
        lines++;
        run_clk = 0;
      end
    end
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CLK * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLK);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
vga_pkg.sv
line_fifo_intf.sv
vga_timing_intf.sv
line_fifo.sv
vga_timing.sv
palette_lookup.sv
video_out.sv
vga_display_top.sv
tb_vga_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vga_display
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= *** TEST FAILED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
